//--- rtl/sys_arr_pkg.sv
package sys_arr_pkg;

    // Array geometry and arithmetic widths
    localparam int N = 4;
    localparam int DW = 8;
    localparam int AW = 20;
    localparam int ROW_W = $clog2(N);

    // Steps from feeder pop to a ready result
    localparam int LAT = 2 * N;

    // Input queue and credit sizing
    localparam int IN_DEPTH = 2;
    localparam int QPTR_W = $clog2(IN_DEPTH);
    localparam int QCNT_W = $clog2(IN_DEPTH + 1);
    localparam int OUT_CREDITS = 4;
    localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);
    localparam int SEQ_W = 8;

    typedef logic signed [DW-1:0] data_t;
    typedef logic signed [AW-1:0] acc_t;

    typedef enum logic {
        kind_weight,
        kind_act
    } beat_kind_t;

    // One queued host beat
    typedef struct packed {
        beat_kind_t kind;
        logic [ROW_W-1:0] row;
        data_t [N-1:0] data;
        acc_t [N-1:0] partial;
    } beat_t;

endpackage

//--- rtl/sys_arr_ctrl_if.sv
interface sys_arr_ctrl_if;
    import sys_arr_pkg::*;

    // Global pipeline advance
    logic step;
    // Head beat leaves the feeder this step
    logic feed_pop;
    // Feeder head state, back to the control unit
    beat_kind_t head_kind;
    logic head_valid;
    // Result register load and its registered copy
    logic out_fire;
    logic out_valid;

    modport control (
        output step, feed_pop, out_fire, out_valid,
        input  head_kind, head_valid
    );

    modport feeder (
        input  feed_pop,
        output head_kind, head_valid
    );

    modport datapath (
        input step, feed_pop, head_kind, out_fire
    );

endinterface

//--- rtl/sys_arr_lane_if.sv
interface sys_arr_lane_if #(
    parameter type lane_t = logic
) ();
    import sys_arr_pkg::*;

    logic shift;
    logic in_valid;
    lane_t [N-1:0] in_lanes;
    lane_t [N-1:0] out_lanes;

    modport writer (
        output shift, in_valid, in_lanes,
        input  out_lanes
    );

    modport fifo (
        input  shift, in_valid, in_lanes,
        output out_lanes
    );

endinterface

//--- rtl/sys_arr_feeder.sv
module sys_arr_feeder (
    input  logic clk,
    input  logic nRST,
    input  logic in_valid,
    input  sys_arr_pkg::beat_kind_t in_kind,
    input  logic [sys_arr_pkg::ROW_W-1:0] in_row,
    input  sys_arr_pkg::data_t [sys_arr_pkg::N-1:0] in_data,
    input  sys_arr_pkg::acc_t [sys_arr_pkg::N-1:0] in_partial,
    output logic in_credit,
    sys_arr_ctrl_if.feeder ctrl,
    output sys_arr_pkg::beat_t head
);
    import sys_arr_pkg::*;

    beat_t queue [IN_DEPTH];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QCNT_W-1:0] count;

    // Host holds a credit for every beat, so a write always finds room
    always_ff @(posedge clk) begin
        if (in_valid) begin
            queue[wr_ptr] <= '{kind: in_kind, row: in_row, data: in_data, partial: in_partial};
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == QPTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (ctrl.feed_pop) begin
                rd_ptr <= (rd_ptr == QPTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid, ctrl.feed_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back per beat that leaves
            in_credit <= ctrl.feed_pop;
        end
    end

    assign head = queue[rd_ptr];
    assign ctrl.head_valid = (count != '0);
    assign ctrl.head_kind = head.kind;

endmodule

//--- rtl/sys_arr_control_unit.sv
module sys_arr_control_unit (
    input  logic clk,
    input  logic nRST,
    sys_arr_ctrl_if.control ctrl,
    input  logic out_credit,
    output logic [sys_arr_pkg::SEQ_W-1:0] out_seq,
    output logic drained
);
    import sys_arr_pkg::*;

    // Tag pipeline follows each activation row through the array
    logic [LAT-1:0] tag_v;
    logic [SEQ_W-1:0] tag_seq [LAT];
    logic [SEQ_W-1:0] next_seq;
    logic [CREDIT_W-1:0] credits;
    logic pop_act;
    logic result_ready;

    assign result_ready = tag_v[LAT-1];

    // Freeze everything when a result waits with no credit left
    assign ctrl.step = !(result_ready && credits == '0);
    assign ctrl.out_fire = result_ready && credits != '0;
    assign ctrl.feed_pop = ctrl.step && ctrl.head_valid;
    assign pop_act = ctrl.feed_pop && ctrl.head_kind == kind_act;

    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            tag_v <= '0;
            next_seq <= '0;
        end else if (ctrl.step) begin
            tag_v <= {tag_v[LAT-2:0], pop_act};
            if (pop_act) begin
                next_seq <= next_seq + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.step) begin
            tag_seq[0] <= next_seq;
            for (int k = 1; k < LAT; k++) begin
                tag_seq[k] <= tag_seq[k-1];
            end
        end
    end

    // Spend on fire, regain on each returned pulse
    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            credits <= CREDIT_W'(OUT_CREDITS);
        end else if (ctrl.out_fire && !out_credit) begin
            credits <= credits - 1'b1;
        end else if (!ctrl.out_fire && out_credit) begin
            credits <= credits + 1'b1;
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            ctrl.out_valid <= 1'b0;
            out_seq <= '0;
            drained <= 1'b1;
        end else begin
            ctrl.out_valid <= ctrl.out_fire;
            if (ctrl.out_fire) begin
                out_seq <= tag_seq[LAT-1];
            end
            drained <= (tag_v == '0) && !ctrl.head_valid;
        end
    end

endmodule

//--- rtl/sys_arr_skew_fifo.sv
module sys_arr_skew_fifo #(
    parameter type lane_t = logic,
    parameter int BASE = 0
) (
    input  logic clk,
    input  logic nRST,
    sys_arr_lane_if.fifo lanes
);
    import sys_arr_pkg::*;

    // Lane i holds BASE+i+1 registers: the write plus BASE+i more shifts
    for (genvar i = 0; i < N; i++) begin : g_lane
        localparam int DEPTH = BASE + i + 1;

        lane_t pipe [DEPTH];

        always_ff @(posedge clk, negedge nRST) begin
            if (nRST == 1'b0) begin
                for (int j = 0; j < DEPTH; j++) begin
                    pipe[j] <= '0;
                end
            end else if (lanes.shift) begin
                // Bubbles travel as zero
                pipe[0] <= lanes.in_valid ? lanes.in_lanes[i] : '0;
                for (int j = 1; j < DEPTH; j++) begin
                    pipe[j] <= pipe[j-1];
                end
            end
        end

        assign lanes.out_lanes[i] = pipe[DEPTH-1];
    end

endmodule

//--- rtl/sys_arr_pe.sv
module sys_arr_pe (
    input  logic clk,
    input  logic nRST,
    input  logic step,
    input  sys_arr_pkg::data_t act_in,
    input  sys_arr_pkg::data_t weight,
    input  sys_arr_pkg::acc_t sum_in,
    output sys_arr_pkg::data_t act_out,
    output sys_arr_pkg::acc_t sum_out
);
    import sys_arr_pkg::*;

    acc_t mac;

    // Signed product widened to the accumulator, wraps mod 2^AW
    assign mac = sum_in + act_in * weight;

    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            act_out <= '0;
            sum_out <= '0;
        end else if (step) begin
            act_out <= act_in;
            sum_out <= mac;
        end
    end

endmodule

//--- rtl/sys_arr_grid.sv
module sys_arr_grid (
    input  logic clk,
    input  logic nRST,
    sys_arr_ctrl_if.datapath ctrl,
    input  logic [sys_arr_pkg::ROW_W-1:0] w_row,
    input  sys_arr_pkg::data_t [sys_arr_pkg::N-1:0] w_data,
    input  sys_arr_pkg::data_t [sys_arr_pkg::N-1:0] act_lanes,
    output sys_arr_pkg::acc_t [sys_arr_pkg::N-1:0] col_sums
);
    import sys_arr_pkg::*;

    // Stationary weights, one row per register
    data_t [N-1:0] w_reg [N];
    // Activations move right, sums move down
    data_t act_h [N][N+1];
    acc_t sum_v [N+1][N];

    always_ff @(posedge clk) begin
        if (ctrl.feed_pop && ctrl.head_kind == kind_weight) begin
            w_reg[w_row] <= w_data;
        end
    end

    for (genvar k = 0; k < N; k++) begin : g_row
        assign act_h[k][0] = act_lanes[k];

        for (genvar c = 0; c < N; c++) begin : g_col
            sys_arr_pe pe (
                .clk(clk),
                .nRST(nRST),
                .step(ctrl.step),
                .act_in(act_h[k][c]),
                .weight(w_reg[k][c]),
                .sum_in(sum_v[k][c]),
                .act_out(act_h[k][c+1]),
                .sum_out(sum_v[k+1][c])
            );
        end
    end

    for (genvar c = 0; c < N; c++) begin : g_edge
        // Top row starts from zero
        assign sum_v[0][c] = '0;
        assign col_sums[c] = sum_v[N][c];
    end

endmodule

//--- rtl/sys_arr_out_stage.sv
module sys_arr_out_stage (
    input  logic clk,
    input  logic nRST,
    sys_arr_ctrl_if.datapath ctrl,
    input  sys_arr_pkg::acc_t [sys_arr_pkg::N-1:0] col_sums,
    input  sys_arr_pkg::acc_t [sys_arr_pkg::N-1:0] partials,
    output sys_arr_pkg::acc_t [sys_arr_pkg::N-1:0] out_data
);
    import sys_arr_pkg::*;

    acc_t [N-1:0] col_total;
    acc_t [N-1:0] aligned;

    for (genvar c = 0; c < N; c++) begin : g_col
        localparam int DELAY = N - 1 - c;

        assign col_total[c] = col_sums[c] + partials[c];

        // Last column finishes last, so it needs no deskew
        if (DELAY == 0) begin : g_direct
            assign aligned[c] = col_total[c];
        end else begin : g_delay
            acc_t dly [DELAY];

            always_ff @(posedge clk, negedge nRST) begin
                if (nRST == 1'b0) begin
                    for (int j = 0; j < DELAY; j++) begin
                        dly[j] <= '0;
                    end
                end else if (ctrl.step) begin
                    dly[0] <= col_total[c];
                    for (int j = 1; j < DELAY; j++) begin
                        dly[j] <= dly[j-1];
                    end
                end
            end

            assign aligned[c] = dly[DELAY-1];
        end
    end

    // Result register
    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            out_data <= '0;
        end else if (ctrl.out_fire) begin
            out_data <= aligned;
        end
    end

endmodule

//--- rtl/systolic_array.sv
module systolic_array (
    input  logic clk,
    input  logic nRST,
    input  logic in_valid,
    input  sys_arr_pkg::beat_kind_t in_kind,
    input  logic [sys_arr_pkg::ROW_W-1:0] in_row,
    input  sys_arr_pkg::data_t [sys_arr_pkg::N-1:0] in_data,
    input  sys_arr_pkg::acc_t [sys_arr_pkg::N-1:0] in_partial,
    input  logic out_credit,
    output logic in_credit,
    output logic out_valid,
    output logic [sys_arr_pkg::SEQ_W-1:0] out_seq,
    output sys_arr_pkg::acc_t [sys_arr_pkg::N-1:0] out_data,
    output logic drained
);
    import sys_arr_pkg::*;

    beat_t head;
    logic act_pop;
    acc_t [N-1:0] col_sums;

    sys_arr_ctrl_if ctrl_bus ();
    sys_arr_lane_if #(.lane_t(data_t)) act_bus ();
    sys_arr_lane_if #(.lane_t(acc_t)) part_bus ();

    sys_arr_feeder feeder (
        .clk(clk),
        .nRST(nRST),
        .in_valid(in_valid),
        .in_kind(in_kind),
        .in_row(in_row),
        .in_data(in_data),
        .in_partial(in_partial),
        .in_credit(in_credit),
        .ctrl(ctrl_bus.feeder),
        .head(head)
    );

    sys_arr_control_unit cu (
        .clk(clk),
        .nRST(nRST),
        .ctrl(ctrl_bus.control),
        .out_credit(out_credit),
        .out_seq(out_seq),
        .drained(drained)
    );

    // Activation rows enter both skew lines together
    assign act_pop = ctrl_bus.feed_pop && head.kind == kind_act;

    assign act_bus.shift = ctrl_bus.step;
    assign act_bus.in_valid = act_pop;
    assign act_bus.in_lanes = head.data;

    assign part_bus.shift = ctrl_bus.step;
    assign part_bus.in_valid = act_pop;
    assign part_bus.in_lanes = head.partial;

    sys_arr_skew_fifo #(.lane_t(data_t), .BASE(0)) act_skew (
        .clk(clk),
        .nRST(nRST),
        .lanes(act_bus.fifo)
    );

    sys_arr_skew_fifo #(.lane_t(acc_t), .BASE(N)) part_skew (
        .clk(clk),
        .nRST(nRST),
        .lanes(part_bus.fifo)
    );

    sys_arr_grid grid (
        .clk(clk),
        .nRST(nRST),
        .ctrl(ctrl_bus.datapath),
        .w_row(head.row),
        .w_data(head.data),
        .act_lanes(act_bus.out_lanes),
        .col_sums(col_sums)
    );

    sys_arr_out_stage out_stage (
        .clk(clk),
        .nRST(nRST),
        .ctrl(ctrl_bus.datapath),
        .col_sums(col_sums),
        .partials(part_bus.out_lanes),
        .out_data(out_data)
    );

    assign out_valid = ctrl_bus.out_valid;

endmodule

//--- verif/systolic_array_assert.sv
module systolic_array_assert (
    input logic clk,
    input logic nRST,
    input logic in_valid,
    input sys_arr_pkg::beat_kind_t in_kind,
    input logic in_credit,
    input logic out_valid,
    input logic [sys_arr_pkg::SEQ_W-1:0] out_seq,
    input logic out_credit,
    input logic drained
);
    timeunit 1ns;
    timeprecision 100ps;
    import sys_arr_pkg::*;

    // Results not yet credited, and input credits the host holds
    int outstanding;
    int in_avail;

    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            outstanding <= 0;
            in_avail <= IN_DEPTH;
        end else begin
            outstanding <= outstanding + int'(out_valid) - int'(out_credit);
            in_avail <= in_avail - int'(in_valid) + int'(in_credit);
        end
    end

    out_credit_limit: assert property (@(posedge clk) disable iff (nRST == 1'b0)
        outstanding + int'(out_valid) <= OUT_CREDITS)
        else $error("More results issued than output credits allow");

    in_credit_held: assert property (@(posedge clk) disable iff (nRST == 1'b0)
        in_valid |-> in_avail + int'(in_credit) > 0)
        else $error("Input beat sent without a credit");

    weight_when_drained: assert property (@(posedge clk) disable iff (nRST == 1'b0)
        in_valid && in_kind == kind_weight |-> drained)
        else $error("Weight beat sent while rows are in flight");

    // Back-to-back valid cycles must be distinct results
    out_valid_pulse: assert property (@(posedge clk) disable iff (nRST == 1'b0)
        out_valid && $past(out_valid) |-> out_seq == SEQ_W'($past(out_seq) + 1'b1))
        else $error("Result valid held without a new sequence number");

endmodule

bind systolic_array systolic_array_assert checks (
    .clk(clk),
    .nRST(nRST),
    .in_valid(in_valid),
    .in_kind(in_kind),
    .in_credit(in_credit),
    .out_valid(out_valid),
    .out_seq(out_seq),
    .out_credit(out_credit),
    .drained(drained)
);

//--- verif/systolic_array_tb.sv
module systolic_array_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import sys_arr_pkg::*;

    typedef data_t [N-1:0] row_data_t;
    typedef acc_t [N-1:0] row_acc_t;

    localparam int RAND_ROWS = 200;
    localparam int EDGE_ROWS = 4;
    localparam int STALL_ROWS = OUT_CREDITS + 2;
    localparam int LATE_ROWS = 20;
    localparam int TOTAL_ROWS = RAND_ROWS + EDGE_ROWS + STALL_ROWS + LATE_ROWS;
    // Roughly 2*LAT cycles per row with slow credits, plus weight loads
    localparam int MAX_CYCLES = TOTAL_ROWS * 2 * LAT + 320;

    logic clk;
    logic nRST;
    logic in_valid;
    beat_kind_t in_kind;
    logic [ROW_W-1:0] in_row;
    row_data_t in_data;
    row_acc_t in_partial;
    logic out_credit;
    logic in_credit;
    logic out_valid;
    logic [SEQ_W-1:0] out_seq;
    row_acc_t out_data;
    logic drained;

    logic [31:0] lfsr = 32'h70e6e3b2;
    row_data_t w_model [N];
    row_acc_t exp_q [$];
    logic [SEQ_W-1:0] exp_seq = '0;
    int in_cred = IN_DEPTH;
    int owed = 0;
    int results = 0;
    int beats_sent = 0;
    int credit_pulses = 0;
    int cycles = 0;
    int data_err = 0;
    int seq_err = 0;
    int flow_err = 0;
    logic hold = 1'b0;
    logic ret_next = 1'b0;

    systolic_array dut (
        .clk(clk),
        .nRST(nRST),
        .in_valid(in_valid),
        .in_kind(in_kind),
        .in_row(in_row),
        .in_data(in_data),
        .in_partial(in_partial),
        .out_credit(out_credit),
        .in_credit(in_credit),
        .out_valid(out_valid),
        .out_seq(out_seq),
        .out_data(out_data),
        .drained(drained)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic row_acc_t model_row(input row_data_t a, input row_acc_t p);
        row_acc_t r;
        int sum;
        for (int c = 0; c < N; c++) begin
            sum = int'(p[c]);
            for (int k = 0; k < N; k++) begin
                sum += int'(a[k]) * int'(w_model[k][c]);
            end
            r[c] = sum[AW-1:0];
        end
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Caller sits 1 ns after a rising edge
    task automatic send_beat(input beat_kind_t kind, input int row, input row_data_t d,
                             input row_acc_t p);
        while (in_cred == 0) begin
            next_cycle();
        end
        in_valid = 1'b1;
        in_kind = kind;
        in_row = ROW_W'(row);
        in_data = d;
        in_partial = p;
        in_cred--;
        beats_sent++;
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic send_act(input row_data_t a, input row_acc_t p);
        exp_q.push_back(model_row(a, p));
        send_beat(kind_act, 0, a, p);
    endtask

    task automatic send_random_act();
        row_data_t a;
        row_acc_t p;
        for (int k = 0; k < N; k++) begin
            a[k] = data_t'(rand_bits(DW));
            p[k] = acc_t'(rand_bits(AW));
        end
        send_act(a, p);
    endtask

    task automatic load_weights(input logic extreme);
        row_data_t w;
        for (int k = 0; k < N; k++) begin
            for (int c = 0; c < N; c++) begin
                w[c] = extreme ? data_t'(8'sh80) : data_t'(rand_bits(DW));
            end
            while (!drained) begin
                next_cycle();
            end
            w_model[k] = w;
            send_beat(kind_weight, k, w, '0);
        end
    endtask

    // All rows back, all credits returned, engine idle
    task automatic wait_quiet();
        while (exp_q.size() != 0 || owed != 0 || ret_next || !drained) begin
            next_cycle();
        end
        repeat (2) next_cycle();
    endtask

    // Outputs sampled at the falling edge half a cycle after they change
    always @(negedge clk) begin
        if (nRST) begin
            if (in_credit) begin
                in_cred++;
                credit_pulses++;
                if (credit_pulses > beats_sent) begin
                    $display("Error at %0t: %0d input credits for %0d beats", $time,
                             credit_pulses, beats_sent);
                    flow_err++;
                end
            end
            if (out_valid) begin
                if (drained) begin
                    $display("Error at %0t: drained high while a result is out", $time);
                    flow_err++;
                end
                if (exp_q.size() == 0) begin
                    $display("A result arrived with no row outstanding at %0t", $time);
                    flow_err++;
                end else if (out_data !== exp_q[0]) begin
                    $display("Error at %0t: row %0d got %h, expected %h", $time, out_seq,
                             out_data, exp_q[0]);
                    data_err++;
                end
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
                if (out_seq !== exp_seq) begin
                    $display("Error at %0t: sequence %0d, expected %0d", $time, out_seq,
                             exp_seq);
                    seq_err++;
                end
                exp_seq++;
                owed++;
                results++;
            end
            ret_next = 1'b0;
            if (!hold && owed > 0 && rand_bits(1) == 1'b1) begin
                ret_next = 1'b1;
                owed--;
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            #1;
            out_credit = ret_next;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        int base;
        nRST = 1'b0;
        in_valid = 1'b0;
        in_kind = kind_weight;
        in_row = '0;
        in_data = '0;
        in_partial = '0;
        out_credit = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        nRST = 1'b1;
        next_cycle();

        // Random weights and rows with random idle gaps
        load_weights(1'b0);
        for (int r = 0; r < RAND_ROWS; r++) begin
            if (rand_bits(2) == 0) begin
                next_cycle();
            end
            send_random_act();
        end
        if (drained) begin
            $display("Error at %0t: drained high with rows in flight", $time);
            flow_err++;
        end
        wait_quiet();

        // Extreme operands wrap modulo 2^20
        load_weights(1'b1);
        send_act({N{8'sh80}}, {N{20'h7ffff}});
        send_act({N{8'sh80}}, {N{20'h80000}});
        send_act({N{8'sh7f}}, {N{20'hfffff}});
        send_act({N{8'sh80}}, {20'h7ffff, 20'h80000, 20'h00001, 20'hfffff});
        wait_quiet();

        // Withheld output credits freeze the array
        hold = 1'b1;
        base = results;
        for (int r = 0; r < STALL_ROWS; r++) begin
            send_random_act();
        end
        while (results - base < OUT_CREDITS) begin
            next_cycle();
        end
        repeat (3 * LAT) next_cycle();
        if (results - base != OUT_CREDITS) begin
            $display("Error at %0t: %0d results without credits, expected %0d", $time,
                     results - base, OUT_CREDITS);
            flow_err++;
        end
        hold = 1'b0;
        wait_quiet();

        // Second weight set applies to later rows only
        load_weights(1'b0);
        for (int r = 0; r < LATE_ROWS; r++) begin
            send_random_act();
        end
        wait_quiet();

        if (in_cred != IN_DEPTH) begin
            $display("Input credits not all returned: %0d of %0d held", in_cred, IN_DEPTH);
            flow_err++;
        end
        $display("Checks done: %0d data errors, %0d sequence errors, %0d flow errors",
                 data_err, seq_err, flow_err);
        if (data_err + seq_err + flow_err == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- list.f
rtl/sys_arr_pkg.sv
rtl/sys_arr_ctrl_if.sv
rtl/sys_arr_lane_if.sv
rtl/sys_arr_feeder.sv
rtl/sys_arr_control_unit.sv
rtl/sys_arr_skew_fifo.sv
rtl/sys_arr_pe.sv
rtl/sys_arr_grid.sv
rtl/sys_arr_out_stage.sv
rtl/systolic_array.sv
verif/systolic_array_assert.sv
verif/systolic_array_tb.sv

//--- Makefile
VERILATOR  := verilator
TOP        := systolic_array_tb
FILELIST   := list.f
FLAGS      := --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary -j 0
LOG        := sim.log
PASS_MSG   := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
